// File: Makefile
# Verilator build and run for the load/store unit testbench

LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
		--top-module lsu_tb -Mdir obj_dir -o lsu_sim

run: compile
	./obj_dir/lsu_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: common/lsu_defines.svh
// width macros for the load/store unit datapath and access encoding
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

//////////////////////
// datapath widths
//////////////////////

`define LSU_DATA_W   32   // address and data path, one word
`define LSU_BE_W     4    // byte lanes per word

//////////////////////
// access encoding
//////////////////////

`define LSU_OFFSET_W 2    // byte offset inside a word
`define LSU_TYPE_W   2    // access size code

// byte lane logic assumes a 32 bit word with four lanes

`endif

// File: common/lsu_fsm_pkg.sv
// transaction controller state encoding
package lsu_fsm_pkg;

  //////////////////////
  // controller states
  //////////////////////

  typedef enum logic [1:0] {
    IDLE                 = 2'b00,  // nothing outstanding
    WAIT_RVALID          = 2'b01,  // granted, ex stage moved on
    WAIT_RVALID_EX_STALL = 2'b10,  // granted, ex stage stalled
    IDLE_EX_STALL        = 2'b11   // data back, ex stage still stalled
  } lsu_state_e;

  // only IDLE and WAIT_RVALID (on rvalid) may issue a new request
  // the stall states hold off new traffic until ex_valid returns

endpackage

// File: common/mem_access_pkg.sv
// memory access types, access size enum
`include "lsu_defines.svh"

package mem_access_pkg;

  //////////////////////
  // access size
  //////////////////////

  // size code as sent by the execute stage
  // 11 is not listed, the datapath decodes it like a byte
  typedef enum logic [`LSU_TYPE_W-1:0] {
    DT_WORD = 2'b00,   // 32 bit access
    DT_HALF = 2'b01,   // 16 bit access
    DT_BYTE = 2'b10    // 8 bit access
  } data_type_e;

  // the size is carried unchanged from execute stage
  // to the request formatter and the load aligner

  // a word must sit on a four byte boundary
  // a halfword may not start at byte offset 3
  // bytes are always aligned

  // all other access attributes travel as plain bits

endpackage

// File: dv/lsu_assert.sv
// handshake and state assertions for the lsu controller, bind into lsu_ctrl
`timescale 1ns/1ps

module lsu_assert
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  lsu_fsm_pkg::lsu_state_e state_q,
  input  logic                    data_req_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic                    data_err_i
);

  // nothing outstanding, so no read data may come back
  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == lsu_fsm_pkg::IDLE) |-> !data_rvalid_i)
    else $error("rvalid seen while controller is idle");

  a_err_with_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    data_err_i |-> data_gnt_i)   // bus error only valid in the address phase
    else $error("bus error without grant");

  // back to back issue only in the rvalid cycle
  a_gnt_wait_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == lsu_fsm_pkg::WAIT_RVALID && data_gnt_i) |-> data_rvalid_i)
    else $error("grant in WAIT_RVALID without rvalid");

  // address phase lasts until the grant
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> data_req_o)
    else $error("request dropped before the grant");

endmodule

bind lsu_ctrl lsu_assert u_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .state_q       (state_q),
  .data_req_o    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .data_err_i    (data_err_i)
);

// File: dv/lsu_tb.sv
// lsu testbench with clock, reset, memory model, lcg, directed tests and summary
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tb;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       data_req_ex_i;
  logic                       data_we_ex_i;
  mem_access_pkg::data_type_e data_type_ex_i;
  logic [`LSU_DATA_W-1:0]     data_wdata_ex_i;
  logic [`LSU_OFFSET_W-1:0]   data_reg_offset_ex_i;
  logic                       data_sign_ext_ex_i;
  logic [`LSU_DATA_W-1:0]     operand_a_ex_i;
  logic [`LSU_DATA_W-1:0]     operand_b_ex_i;
  logic                       addr_useincr_ex_i;
  logic                       ex_valid_i;
  logic [`LSU_DATA_W-1:0]     data_rdata_ex_o;
  logic                       data_misaligned_o;
  logic                       lsu_ready_ex_o;
  logic                       lsu_ready_wb_o;
  logic                       busy_o;
  logic                       load_err_o;
  logic                       store_err_o;
  logic                       data_req_o;
  logic                       data_gnt_i;
  logic                       data_rvalid_i;
  logic                       data_err_i;
  logic [`LSU_DATA_W-1:0]     data_addr_o;
  logic                       data_we_o;
  logic [`LSU_BE_W-1:0]       data_be_o;
  logic [`LSU_DATA_W-1:0]     data_wdata_o;
  logic [`LSU_DATA_W-1:0]     data_rdata_i;

  int          errors;
  int          tests_run;
  int          gnt_wait_total;   // back-pressure cycles seen so far
  bit          hung;             // a wait ran out, skip the rest
  logic [31:0] stim_lcg;
  logic [31:0] ref_mem [0:63];   // expected memory contents

  always #10 clk = ~clk;   // 20 ns period

  lsu_top uut (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // every index bit shows up in the word
  function automatic logic [31:0] fill_word(input logic [5:0] idx);
    return {idx, 2'b10, ~idx, 2'b01, idx ^ 6'h2a, 4'h9, idx};
  endfunction

  //////////////////////
  // memory model
  //////////////////////

  logic [`LSU_DATA_W-1:0] mem [0:63];
  logic [31:0]            gnt_lcg;
  logic [1:0]             gnt_delay;    // hold-off before the next grant
  logic [1:0]             gnt_cnt;
  logic                   rvalid_q;
  logic [`LSU_DATA_W-1:0] rdata_q;
  logic                   err_inject;   // grants carry a bus error

  assign data_gnt_i    = data_req_o && (gnt_cnt == gnt_delay);
  assign data_err_i    = err_inject && data_gnt_i;
  assign data_rvalid_i = rvalid_q;      // one cycle after grant
  assign data_rdata_i  = rdata_q;

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 64; i++)
        mem[i] <= fill_word(i[5:0]);
      gnt_lcg   <= 32'd69668;
      gnt_delay <= 2'd0;
      gnt_cnt   <= 2'd0;
      rvalid_q  <= 1'b0;
      rdata_q   <= '0;
    end
    else
    begin
      rvalid_q <= data_req_o && data_gnt_i;
      if (data_req_o && data_gnt_i)
      begin
        gnt_cnt   <= 2'd0;
        gnt_lcg   <= lcg_next(gnt_lcg);
        gnt_delay <= gnt_lcg[17:16];      // 0 to 3 cycles
        rdata_q   <= mem[data_addr_o[7:2]];
        if (data_we_o && !data_err_i)     // failed stores leave memory alone
          for (int i = 0; i < 4; i++)
            if (data_be_o[i])
              mem[data_addr_o[7:2]][8*i +: 8] <= data_wdata_o[8*i +: 8];
      end
      else if (data_req_o)
        gnt_cnt <= gnt_cnt + 2'd1;
    end
  end

  //////////////////////
  // helpers
  //////////////////////

  task automatic flag_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic test_done(input string name, input int err_start);
    tests_run++;
    $display("%-18s %s, %0d errors", name, (errors == err_start) ? "passed" : "failed",
             errors - err_start);
  endtask

  task automatic next_word(output logic [31:0] w);
    stim_lcg = lcg_next(stim_lcg);
    w        = stim_lcg;
  endtask

  // register byte roff+j lands on lane off+j, both mod 4
  task automatic ref_store(input logic [31:0] addr, input mem_access_pkg::data_type_e dt,
                           input logic [31:0] wd, input logic [1:0] roff);
    int         nb;
    logic [1:0] lane;
    logic [1:0] src;
    nb = (dt == mem_access_pkg::DT_WORD) ? 4 : (dt == mem_access_pkg::DT_HALF) ? 2 : 1;
    for (int j = 0; j < nb; j++)
    begin
      lane = addr[1:0] + j[1:0];
      src  = roff + j[1:0];
      ref_mem[addr[7:2]][{lane, 3'b000} +: 8] = wd[{src, 3'b000} +: 8];
    end
  endtask

  function automatic logic [31:0] expect_load(input logic [31:0] addr,
                                              input mem_access_pkg::data_type_e dt,
                                              input logic sext);
    int          nb;
    logic [1:0]  lane;
    logic [31:0] r;
    nb = (dt == mem_access_pkg::DT_WORD) ? 4 : (dt == mem_access_pkg::DT_HALF) ? 2 : 1;
    r  = '0;
    for (int j = 0; j < nb; j++)
    begin
      lane = addr[1:0] + j[1:0];
      r[{j[1:0], 3'b000} +: 8] = ref_mem[addr[7:2]][{lane, 3'b000} +: 8];
    end
    if (sext && dt == mem_access_pkg::DT_HALF)
      r[31:16] = {16{r[15]}};
    else if (sext && dt != mem_access_pkg::DT_WORD)
      r[31:8] = {24{r[7]}};
    return r;
  endfunction

  task automatic drive_req(input logic we, input mem_access_pkg::data_type_e dt,
                           input logic [31:0] a, input logic [31:0] b, input logic incr,
                           input logic [31:0] wd, input logic [1:0] roff, input logic sext,
                           input logic exv);
    @(negedge clk);
    data_req_ex_i        = 1'b1;
    data_we_ex_i         = we;
    data_type_ex_i       = dt;
    operand_a_ex_i       = a;
    operand_b_ex_i       = b;
    addr_useincr_ex_i    = incr;
    data_wdata_ex_i      = wd;
    data_reg_offset_ex_i = roff;
    data_sign_ext_ex_i   = sext;
    ex_valid_i           = exv;
    #2;   // settle before sampling
  endtask

  // returns in the grant cycle
  task automatic wait_grant();
    int waited;
    waited = 0;
    while (!data_gnt_i && waited < 20)
    begin
      if (!data_req_o || lsu_ready_ex_o || !busy_o || load_err_o || store_err_o)
        flag_mismatch("req/ready/busy/error wrong while waiting for grant");
      @(negedge clk);
      #2;
      waited++;
    end
    gnt_wait_total += waited;
    if (!data_gnt_i)
    begin
      $display("timeout: the memory never granted the request");
      errors++;
      hung = 1'b1;
    end
    else if (!lsu_ready_ex_o)
      flag_mismatch("lsu_ready_ex_o low in the grant cycle");
  endtask

  // returns in the rvalid cycle with the value seen on data_rdata_ex_o
  task automatic wait_rvalid(output logic [31:0] rd);
    int waited;
    waited = 0;
    @(negedge clk);
    data_req_ex_i = 1'b0;
    #2;
    while (!data_rvalid_i && waited < 20)
    begin
      if (!busy_o || (ex_valid_i && lsu_ready_wb_o))
        flag_mismatch("busy/ready_wb wrong while waiting for rvalid");
      @(negedge clk);
      #2;
      waited++;
    end
    rd = data_rdata_ex_o;
    if (!data_rvalid_i)
    begin
      $display("timeout: no rvalid after the grant");
      errors++;
      hung = 1'b1;
    end
    else if (!busy_o || !lsu_ready_wb_o)
      flag_mismatch("busy_o or lsu_ready_wb_o low in the rvalid cycle");
  endtask

  task automatic run_access(input logic we, input mem_access_pkg::data_type_e dt,
                            input logic [31:0] a, input logic [31:0] b, input logic incr,
                            input logic [31:0] wd, input logic [1:0] roff, input logic sext,
                            output logic [31:0] rd);
    logic [31:0] exp_addr;
    rd = '0;
    if (hung)
      return;
    exp_addr = incr ? a + b : a;
    drive_req(we, dt, a, b, incr, wd, roff, sext, 1'b1);
    wait_grant();
    if (hung)
      return;
    if (data_addr_o != exp_addr)
      flag_mismatch($sformatf("address %h, expected %h", data_addr_o, exp_addr));
    wait_rvalid(rd);
    if (hung)
      return;
    @(negedge clk);
    #2;
    if (busy_o)
      flag_mismatch("busy_o still high after completion");
  endtask

  //////////////////////
  // directed tests
  //////////////////////

  task automatic test_word_access();
    int          err_start;
    logic [31:0] wd;
    logic [31:0] rd;
    err_start = errors;
    next_word(wd);
    run_access(1'b1, mem_access_pkg::DT_WORD, 32'h30, 32'h10, 1'b1, wd, 2'd0, 1'b0, rd);
    ref_store(32'h40, mem_access_pkg::DT_WORD, wd, 2'd0);
    run_access(1'b0, mem_access_pkg::DT_WORD, 32'h40, 32'h77, 1'b0, '0, 2'd0, 1'b0, rd);
    if (rd != wd)
      flag_mismatch($sformatf("word load got %h, expected %h", rd, wd));
    next_word(wd);
    run_access(1'b1, mem_access_pkg::DT_WORD, 32'h54, 32'h99, 1'b0, wd, 2'd0, 1'b0, rd);
    ref_store(32'h54, mem_access_pkg::DT_WORD, wd, 2'd0);
    run_access(1'b0, mem_access_pkg::DT_WORD, 32'h50, 32'h4, 1'b1, '0, 2'd0, 1'b0, rd);
    if (rd != wd)
      flag_mismatch($sformatf("word load got %h, expected %h", rd, wd));
    test_done("word access", err_start);
  endtask

  task automatic test_subword();
    int                         err_start;
    logic [31:0]                wd;
    logic [31:0]                rd;
    logic [31:0]                addr;
    logic [1:0]                 off;
    logic [1:0]                 roff;
    mem_access_pkg::data_type_e dt;
    err_start = errors;
    for (int k = 0; k < 7; k++)
    begin
      dt   = (k < 4) ? mem_access_pkg::DT_BYTE : mem_access_pkg::DT_HALF;
      off  = k[1:0];   // bytes at 0..3, halves at 0..2
      roff = k[2:1];   // rotation amounts 0 to 3 all show up
      addr = {24'h0, 2'b10, 1'b0, k[2:0], off};
      next_word(wd);
      run_access(1'b1, dt, addr, '0, 1'b0, wd, roff, 1'b0, rd);
      ref_store(addr, dt, wd, roff);
      for (int s = 0; s < 2; s++)   // zero then sign extension
      begin
        run_access(1'b0, dt, addr, '0, 1'b0, '0, 2'd0, s[0], rd);
        if (rd != expect_load(addr, dt, s[0]))
          flag_mismatch($sformatf("load at %h got %h, expected %h", addr, rd,
                                  expect_load(addr, dt, s[0])));
      end
      // untouched lanes keep their old bytes
      run_access(1'b0, mem_access_pkg::DT_WORD, {addr[31:2], 2'b00}, '0, 1'b0, '0, 2'd0,
                 1'b0, rd);
      if (rd != ref_mem[addr[7:2]])
        flag_mismatch($sformatf("word at %h is %h, expected %h", addr, rd, ref_mem[addr[7:2]]));
    end
    test_done("byte/halfword", err_start);
  endtask

  task automatic test_misaligned();
    int                         err_start;
    logic [31:0]                rd;
    logic [1:0]                 off;
    mem_access_pkg::data_type_e dt;
    err_start = errors;
    for (int k = 1; k < 5; k++)
    begin
      dt  = (k < 4) ? mem_access_pkg::DT_WORD : mem_access_pkg::DT_HALF;
      off = (k < 4) ? k[1:0] : 2'd3;
      drive_req(1'b1, dt, {24'h0, 6'h30, off}, '0, 1'b0, 32'hdead_beef, 2'd0, 1'b0, 1'b1);
      if (!data_misaligned_o || data_req_o || !lsu_ready_ex_o || busy_o)
        flag_mismatch($sformatf("misaligned access at offset %0d not blocked", off));
      @(negedge clk);
      #2;
      if (!data_misaligned_o || data_req_o || !lsu_ready_ex_o || busy_o)
        flag_mismatch("misaligned access not blocked one cycle later");
      @(negedge clk);
      data_req_ex_i = 1'b0;
    end
    run_access(1'b0, mem_access_pkg::DT_WORD, 32'hc0, '0, 1'b0, '0, 2'd0, 1'b0, rd);
    if (rd != ref_mem[6'h30])
      flag_mismatch($sformatf("word at c0 changed to %h", rd));
    test_done("misaligned", err_start);
  endtask

  task automatic test_grant_delay();
    int          err_start;
    logic [31:0] wd;
    logic [31:0] rd;
    logic [31:0] addr;
    err_start = errors;
    gnt_wait_total = 0;
    for (int k = 0; k < 8; k++)
    begin
      next_word(wd);
      addr = {24'h0, wd[13:8], 2'b00};
      run_access(1'b1, mem_access_pkg::DT_WORD, addr, '0, 1'b0, wd, 2'd0, 1'b0, rd);
      ref_store(addr, mem_access_pkg::DT_WORD, wd, 2'd0);
      run_access(1'b0, mem_access_pkg::DT_WORD, addr, '0, 1'b0, '0, 2'd0, 1'b0, rd);
      if (rd != wd)
        flag_mismatch($sformatf("load at %h got %h, expected %h", addr, rd, wd));
    end
    if (gnt_wait_total == 0)
    begin
      $display("no grant was ever delayed, back-pressure untested");
      errors++;
    end
    test_done("grant delay", err_start);
  endtask

  task automatic test_ex_stall();
    int          err_start;
    logic [31:0] rd;
    logic [31:0] exp;
    err_start = errors;
    exp = expect_load(32'h20, mem_access_pkg::DT_HALF, 1'b1);
    drive_req(1'b0, mem_access_pkg::DT_HALF, 32'h20, '0, 1'b0, '0, 2'd0, 1'b1, 1'b0);
    wait_grant();
    if (!hung)
      wait_rvalid(rd);
    if (!hung && rd != exp)
      flag_mismatch($sformatf("stalled load got %h, expected %h", rd, exp));
    for (int c = 0; c < 3 && !hung; c++)   // ex stage still frozen
    begin
      @(negedge clk);
      #2;
      if (data_rdata_ex_o != exp || !busy_o)
        flag_mismatch("load value or busy_o lost during ex stall");
    end
    @(negedge clk);
    ex_valid_i = 1'b1;
    @(negedge clk);
    #2;
    if (busy_o || data_rdata_ex_o != exp)
      flag_mismatch("busy_o high or load value lost after stall release");
    test_done("ex stall", err_start);
  endtask

  task automatic test_bus_error();
    int          err_start;
    logic [31:0] rd;
    err_start  = errors;
    err_inject = 1'b1;
    for (int w = 0; w < 2 && !hung; w++)   // load first, then store
    begin
      drive_req(w[0], mem_access_pkg::DT_WORD, 32'h10, '0, 1'b0, 32'h1234_5678, 2'd0,
                1'b0, 1'b1);
      wait_grant();
      if (!hung && (load_err_o != !w[0] || store_err_o != w[0]))
        flag_mismatch($sformatf("error flags load %b store %b on we=%0d", load_err_o,
                                store_err_o, w));
      if (!hung)
        wait_rvalid(rd);
    end
    err_inject = 1'b0;
    run_access(1'b0, mem_access_pkg::DT_WORD, 32'h10, '0, 1'b0, '0, 2'd0, 1'b0, rd);
    if (rd != ref_mem[4])
      flag_mismatch($sformatf("failed store changed memory to %h", rd));
    test_done("bus error", err_start);
  endtask

  //////////////////////
  // main sequence
  //////////////////////

  initial
  begin
    rst_n                = 1'b0;
    data_req_ex_i        = 1'b0;
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = mem_access_pkg::DT_WORD;
    data_wdata_ex_i      = '0;
    data_reg_offset_ex_i = '0;
    data_sign_ext_ex_i   = 1'b0;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    addr_useincr_ex_i    = 1'b0;
    ex_valid_i           = 1'b1;
    err_inject           = 1'b0;
    errors               = 0;
    tests_run            = 0;
    gnt_wait_total       = 0;
    hung                 = 1'b0;
    stim_lcg             = 32'd69668;
    for (int i = 0; i < 64; i++)
      ref_mem[i] = fill_word(i[5:0]);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #2;
    if (!lsu_ready_ex_o || !lsu_ready_wb_o || busy_o || load_err_o || store_err_o ||
        data_req_o || data_rdata_ex_o != '0)
      flag_mismatch("outputs wrong after reset");
    if (!hung)
      test_word_access();
    if (!hung)
      test_subword();
    if (!hung)
      test_misaligned();
    if (!hung)
      test_grant_delay();
    if (!hung)
      test_ex_stall();
    if (!hung)
      test_bus_error();
    $display("%0d tests run, %0d checks failed", tests_run, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: lsu/lsu_ctrl.sv
// lsu transaction controller with request gating, ready/busy flags and bus error flags
`timescale 1ns/1ps

module lsu_ctrl
(
  input  logic clk,
  input  logic rst_n,

  // execute stage side
  input  logic data_req_ex_i,   // access wanted this cycle
  input  logic data_we_i,       // store when high
  input  logic misaligned_i,    // from the request formatter
  input  logic ex_valid_i,      // ex stage advances this cycle

  // memory handshake
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,
  output logic data_req_o,

  // status
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic busy_o,
  output logic load_err_o,
  output logic store_err_o
);

  lsu_fsm_pkg::lsu_state_e state_q;     // current state
  lsu_fsm_pkg::lsu_state_e state_d;     // next state
  lsu_fsm_pkg::lsu_state_e gnt_state;   // target of a granted access
  logic                    req_ok;      // access that may go to memory

  // misaligned accesses are flagged upstream and never issued
  assign req_ok = data_req_ex_i & ~misaligned_i;

  // a stalled ex stage must be remembered until rvalid
  assign gnt_state = ex_valid_i ? lsu_fsm_pkg::WAIT_RVALID
                                : lsu_fsm_pkg::WAIT_RVALID_EX_STALL;

  //////////////////////
  // state register
  //////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= lsu_fsm_pkg::IDLE;
    else
      state_q <= state_d;
  end

  //////////////////////
  // next state / req
  //////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      lsu_fsm_pkg::IDLE:
      begin
        data_req_o = req_ok;
        if (req_ok)
        begin
          lsu_ready_ex_o = data_gnt_i;      // stall ex until address phase done
          if (data_gnt_i)
            state_d = gnt_state;
        end
      end

      lsu_fsm_pkg::WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;     // wb waits on returning data
        if (data_rvalid_i)
        begin
          data_req_o = req_ok;              // back to back issue allowed
          if (req_ok)
          begin
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = gnt_state;
            else
              state_d = lsu_fsm_pkg::IDLE;  // keep requesting from IDLE
          end
          else
          begin
            state_d = lsu_fsm_pkg::IDLE;
          end
        end
      end

      lsu_fsm_pkg::WAIT_RVALID_EX_STALL:
      begin
        // no new request while the ex stage is frozen
        if (data_rvalid_i)
          state_d = ex_valid_i ? lsu_fsm_pkg::IDLE : lsu_fsm_pkg::IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = lsu_fsm_pkg::WAIT_RVALID;   // stall lifted before data
      end

      lsu_fsm_pkg::IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = lsu_fsm_pkg::IDLE;
      end

      default:
      begin
        state_d = lsu_fsm_pkg::IDLE;
      end
    endcase
  end

  //////////////////////
  // status outputs
  //////////////////////

  assign busy_o = (state_q != lsu_fsm_pkg::IDLE) | data_req_o;

  // bus error arrives with the grant, split by access kind
  assign load_err_o  = data_gnt_i & data_err_i & ~data_we_i;
  assign store_err_o = data_gnt_i & data_err_i &  data_we_i;

endmodule

// File: lsu/lsu_rdata_align.sv
// access attribute capture at grant, load alignment with sign extension, load hold register
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_rdata_align
(
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       data_gnt_i,      // address phase done
  input  logic                       data_rvalid_i,   // data phase done
  input  logic                       data_we_i,
  input  mem_access_pkg::data_type_e data_type_i,
  input  logic                       data_sign_ext_i, // sign extend loads
  input  logic [`LSU_OFFSET_W-1:0]   addr_offset_i,   // low address bits
  input  logic [`LSU_DATA_W-1:0]     data_rdata_i,    // raw word from memory

  output logic [`LSU_DATA_W-1:0]     data_rdata_ex_o  // aligned load result
);

  // attributes of the outstanding access
  mem_access_pkg::data_type_e data_type_q;
  logic [`LSU_OFFSET_W-1:0]   offset_q;
  logic                       sign_ext_q;
  logic                       we_q;

  logic [`LSU_DATA_W-1:0]     rdata_shift;   // addressed lane moved to bit 0
  logic [`LSU_DATA_W-1:0]     rdata_ext;     // extended result
  logic [`LSU_DATA_W-1:0]     rdata_q;       // last load value

  //////////////////////
  // capture at grant
  //////////////////////

  // the execute stage may move on after the grant, so keep a copy
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_type_q <= mem_access_pkg::DT_WORD;
      offset_q    <= '0;
      sign_ext_q  <= 1'b0;
      we_q        <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      data_type_q <= data_type_i;
      offset_q    <= addr_offset_i;
      sign_ext_q  <= data_sign_ext_i;
      we_q        <= data_we_i;
    end
  end

  //////////////////////
  // alignment
  //////////////////////

  always_comb
  begin
    case (offset_q)
      2'b00:   rdata_shift = data_rdata_i;
      2'b01:   rdata_shift = {8'h00,  data_rdata_i[31:8]};
      2'b10:   rdata_shift = {16'h0000, data_rdata_i[31:16]};
      default: rdata_shift = {24'h00_0000, data_rdata_i[31:24]};
    endcase
  end

  // zero or sign extension by access size
  always_comb
  begin
    case (data_type_q)
      mem_access_pkg::DT_WORD:
        rdata_ext = data_rdata_i;   // words are always aligned
      mem_access_pkg::DT_HALF:
        rdata_ext = {{16{sign_ext_q & rdata_shift[15]}}, rdata_shift[15:0]};
      default:
        rdata_ext = {{24{sign_ext_q & rdata_shift[7]}}, rdata_shift[7:0]};
    endcase
  end

  //////////////////////
  // hold register
  //////////////////////

  // store acks leave the previous load value untouched
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !we_q)
      rdata_q <= rdata_ext;
  end

  // live value in the rvalid cycle, held value afterwards
  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

// File: lsu/lsu_req_format.sv
// address generation, misalignment check, byte enables and store data rotation
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_req_format
(
  input  logic [`LSU_DATA_W-1:0]   operand_a_i,       // base address
  input  logic [`LSU_DATA_W-1:0]   operand_b_i,       // increment
  input  logic                     addr_useincr_i,    // a + b when high
  input  mem_access_pkg::data_type_e data_type_i,
  input  logic [`LSU_DATA_W-1:0]   data_wdata_i,      // store data as in register
  input  logic [`LSU_OFFSET_W-1:0] data_reg_offset_i, // byte position in register
  input  logic                     data_req_i,

  output logic [`LSU_DATA_W-1:0]   data_addr_o,
  output logic [`LSU_BE_W-1:0]     data_be_o,
  output logic [`LSU_DATA_W-1:0]   data_wdata_o,
  output logic [`LSU_OFFSET_W-1:0] addr_offset_o,     // to the load aligner
  output logic                     misaligned_o
);

  logic [`LSU_DATA_W-1:0]   addr_int;
  logic [`LSU_OFFSET_W-1:0] wdata_rot;   // lanes to rotate the store word left

  assign addr_int      = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign data_addr_o   = addr_int;
  assign addr_offset_o = addr_int[`LSU_OFFSET_W-1:0];

  //////////////////////
  // misalignment
  //////////////////////

  always_comb
  begin
    misaligned_o = 1'b0;
    if (data_req_i)
    begin
      case (data_type_i)
        mem_access_pkg::DT_WORD: misaligned_o = (addr_offset_o != 2'b00);
        mem_access_pkg::DT_HALF: misaligned_o = (addr_offset_o == 2'b11);
        default:                 misaligned_o = 1'b0;   // bytes always fit
      endcase
    end
  end

  //////////////////////
  // byte enables
  //////////////////////

  always_comb
  begin
    case (data_type_i)
      mem_access_pkg::DT_WORD: data_be_o = 4'b1111;
      mem_access_pkg::DT_HALF:
      begin
        case (addr_offset_o)
          2'b00:   data_be_o = 4'b0011;
          2'b01:   data_be_o = 4'b0110;
          2'b10:   data_be_o = 4'b1100;
          default: data_be_o = 4'b1000;   // misaligned, never issued
        endcase
      end
      default:   // byte, code 11 included
      begin
        case (addr_offset_o)
          2'b00:   data_be_o = 4'b0001;
          2'b01:   data_be_o = 4'b0010;
          2'b10:   data_be_o = 4'b0100;
          default: data_be_o = 4'b1000;
        endcase
      end
    endcase
  end

  //////////////////////
  // store rotation
  //////////////////////

  // register byte at reg offset ends up on the addressed lane, mod 4
  assign wdata_rot = addr_offset_o - data_reg_offset_i;

  always_comb
  begin
    case (wdata_rot)
      2'b00:   data_wdata_o = data_wdata_i;
      2'b01:   data_wdata_o = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'b10:   data_wdata_o = {data_wdata_i[15:0], data_wdata_i[31:16]};
      default: data_wdata_o = {data_wdata_i[7:0],  data_wdata_i[31:8]};
    endcase
  end

endmodule

// File: source/lsu_top.sv
// load/store unit top level, request formatter, controller and load aligner
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top
(
  input  logic                       clk,
  input  logic                       rst_n,

  // execute stage
  input  logic                       data_req_ex_i,
  input  logic                       data_we_ex_i,
  input  mem_access_pkg::data_type_e data_type_ex_i,
  input  logic [`LSU_DATA_W-1:0]     data_wdata_ex_i,
  input  logic [`LSU_OFFSET_W-1:0]   data_reg_offset_ex_i,
  input  logic                       data_sign_ext_ex_i,
  input  logic [`LSU_DATA_W-1:0]     operand_a_ex_i,
  input  logic [`LSU_DATA_W-1:0]     operand_b_ex_i,
  input  logic                       addr_useincr_ex_i,
  input  logic                       ex_valid_i,

  output logic [`LSU_DATA_W-1:0]     data_rdata_ex_o,
  output logic                       data_misaligned_o,
  output logic                       lsu_ready_ex_o,
  output logic                       lsu_ready_wb_o,
  output logic                       busy_o,
  output logic                       load_err_o,
  output logic                       store_err_o,

  // data memory
  output logic                       data_req_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic                       data_err_i,
  output logic [`LSU_DATA_W-1:0]     data_addr_o,
  output logic                       data_we_o,
  output logic [`LSU_BE_W-1:0]       data_be_o,
  output logic [`LSU_DATA_W-1:0]     data_wdata_o,
  input  logic [`LSU_DATA_W-1:0]     data_rdata_i
);

  logic [`LSU_OFFSET_W-1:0] addr_offset;  // low address bits for the aligner
  logic                     misaligned;

  assign data_misaligned_o = misaligned;
  assign data_we_o         = data_we_ex_i;   // held by ex until grant

  lsu_req_format u_req_format (
    .operand_a_i       (operand_a_ex_i),
    .operand_b_i       (operand_b_ex_i),
    .addr_useincr_i    (addr_useincr_ex_i),
    .data_type_i       (data_type_ex_i),
    .data_wdata_i      (data_wdata_ex_i),
    .data_reg_offset_i (data_reg_offset_ex_i),
    .data_req_i        (data_req_ex_i),
    .data_addr_o       (data_addr_o),
    .data_be_o         (data_be_o),
    .data_wdata_o      (data_wdata_o),
    .addr_offset_o     (addr_offset),
    .misaligned_o      (misaligned)
  );

  lsu_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_we_i      (data_we_ex_i),
    .misaligned_i   (misaligned),
    .ex_valid_i     (ex_valid_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_we_i       (data_we_ex_i),
    .data_type_i     (data_type_ex_i),
    .data_sign_ext_i (data_sign_ext_ex_i),
    .addr_offset_i   (addr_offset),
    .data_rdata_i    (data_rdata_i),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

endmodule

// File: src.f
+incdir+common
common/mem_access_pkg.sv
common/lsu_fsm_pkg.sv
lsu/lsu_req_format.sv
lsu/lsu_ctrl.sv
lsu/lsu_rdata_align.sv
source/lsu_top.sv
dv/lsu_assert.sv
dv/lsu_tb.sv
